//--- bench/exeModel.svh
`ifndef EXE_MODEL_SVH
`define EXE_MODEL_SVH

// true when a + b leaves the signed 32-bit range
function automatic logic addOverflows(input logic [31:0] a, input logic [31:0] b);
	longint sum;
	sum = longint'($signed(a)) + longint'($signed(b));
	return sum != longint'($signed(sum[31:0]));
endfunction

// same for a - b
function automatic logic subOverflows(input logic [31:0] a, input logic [31:0] b);
	longint diff;
	diff = longint'($signed(a)) - longint'($signed(b));
	return diff != longint'($signed(diff[31:0]));
endfunction

// expected stage output for one instruction
function automatic exePkg::exeOut expectedOut(input exePkg::exeIn x);
	exePkg::exeOut e;
	logic [31:0] a;
	logic [31:0] rt;
	logic [31:0] signImm;
	logic [31:0] zeroImm;
	logic [4:0] sh;
	e = '0;
	e.valid = x.valid;
	a = x.rsValue;
	rt = x.rtValue;
	sh = x.instr.r.shamt;
	signImm = {{16{x.instr.i.imm[15]}}, x.instr.i.imm};
	zeroImm = {16'h0000, x.instr.i.imm};
	if (x.instr.r.opcode == exePkg::opcodeRtype)
	begin
		case (x.instr.r.funct)
			exePkg::functAdd:
			begin
				e.result = a + rt;
				e.overflow = addOverflows(a, rt);
			end
			exePkg::functAddu:
				e.result = a + rt;
			exePkg::functSub:
			begin
				e.result = a - rt;
				e.overflow = subOverflows(a, rt);
				e.zero = (a == rt) && !e.overflow;
			end
			exePkg::functSubu:
			begin
				e.result = a - rt;
				e.zero = (a == rt);
			end
			exePkg::functAnd:
				e.result = a & rt;
			exePkg::functOr:
				e.result = a | rt;
			exePkg::functNor:
				e.result = ~(a | rt);
			exePkg::functSlt:
				e.result = {31'b0, $signed(a) < $signed(rt)};
			exePkg::functSltu:
				e.result = {31'b0, a < rt};
			exePkg::functSll:
				e.result = rt << sh;
			exePkg::functSrl:
				e.result = rt >> sh;
			exePkg::functSra:
				e.result = $signed(rt) >>> sh;
			// variable forms shift by rs
			exePkg::functSllv:
				e.result = rt << a[4:0];
			exePkg::functSrlv:
				e.result = rt >> a[4:0];
			exePkg::functJr:
				e.result = a;
			default:
				e.result = '0;
		endcase
	end
	else
	begin
		case (x.instr.i.opcode)
			exePkg::opcodeAddi:
			begin
				e.result = a + signImm;
				e.overflow = addOverflows(a, signImm);
			end
			exePkg::opcodeAddiu:
				e.result = a + signImm;
			exePkg::opcodeSlti:
				e.result = {31'b0, $signed(a) < $signed(signImm)};
			exePkg::opcodeSltiu:
				e.result = {31'b0, a < signImm};
			exePkg::opcodeAndi:
				e.result = a & zeroImm;
			exePkg::opcodeOri:
				e.result = a | zeroImm;
			exePkg::opcodeLui:
				e.result = {x.instr.i.imm, 16'h0000};
			// beq compares rs with the sign-extended immediate
			exePkg::opcodeBeq:
			begin
				e.result = a - signImm;
				e.overflow = subOverflows(a, signImm);
				e.zero = (a == signImm) && !e.overflow;
			end
			default:
				e.result = '0;
		endcase
	end
	return e;
endfunction

`endif

//--- bench/exeStageTb.sv
module exeStageTb;

	// run length from per-test stimulus plus drain
	localparam int resetCycles = 2;
	localparam int drainCycles = 4;
	localparam int testCount = 6;
	localparam int testCycles = 7 + 27 + 20 + 24 + 22 + 11;
	localparam int timeoutCycles = resetCycles + testCycles + testCount * drainCycles + 20;

	// r-type alu functs for test 2
	localparam logic [5:0] aluFuncts [9] = '{exePkg::functAdd, exePkg::functAddu,
		exePkg::functSub, exePkg::functSubu, exePkg::functAnd, exePkg::functOr,
		exePkg::functNor, exePkg::functSlt, exePkg::functSltu};
	// signed limit pairs for overflow
	localparam logic [31:0] cornerA [4] = '{32'h7fffffff, 32'h80000000, 32'h80000000,
		32'h7fffffff};
	localparam logic [31:0] cornerB [4] = '{32'h00000001, 32'hffffffff, 32'h00000001,
		32'hffffffff};

	// expected output and the cycle it is due
	typedef struct packed
	{
		logic [31:0] due;
		exePkg::exeOut exp;
	} pendingOut;

	logic clk;
	logic rstN;
	exePkg::exeIn dutIn;
	exePkg::exeOut dutOut;
	logic [31:0] cycleCount = 0;
	int errorCount = 0;
	int passCount = 0;
	int failCount = 0;
	pendingOut expected [$];

	`include "exeModel.svh"

	exeStage u_dut
	(
		.clk(clk),
		.rstN(rstN),
		.in(dutIn),
		.out(dutOut)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	function automatic exePkg::instrWord rType(input logic [5:0] funct, input logic [4:0] sh);
		exePkg::instrWord w;
		w.r.opcode = exePkg::opcodeRtype;
		w.r.rs = 5'd1;
		w.r.rt = 5'd2;
		w.r.rd = 5'd3;
		w.r.shamt = sh;
		w.r.funct = funct;
		return w;
	endfunction

	function automatic exePkg::instrWord iType(input logic [5:0] opcode, input logic [15:0] imm);
		exePkg::instrWord w;
		w.i.opcode = opcode;
		w.i.rs = 5'd1;
		w.i.rt = 5'd2;
		w.i.imm = imm;
		return w;
	endfunction

	// one instruction per falling edge and valid ones go to the scoreboard
	task automatic send(input exePkg::instrWord instr, input logic [31:0] rsVal,
		input logic [31:0] rtVal, input logic valid);
		pendingOut entry;
		@(negedge clk);
		dutIn.valid = valid;
		dutIn.instr = instr;
		dutIn.rsValue = rsVal;
		dutIn.rtValue = rtVal;
		if (valid)
		begin
			// sampled next edge and out two edges later
			entry.due = cycleCount + 2;
			entry.exp = expectedOut(dutIn);
			expected.push_back(entry);
		end
	endtask

	// bubble in and wait for the pipe to empty before scoring the test
	task automatic reportTest(input string name, input int errorsBefore);
		@(negedge clk);
		dutIn.valid = 1'b0;
		while (expected.size() != 0)
			@(negedge clk);
		@(negedge clk);
		if (errorCount == errorsBefore)
		begin
			passCount++;
			$display("test %s: ok", name);
		end
		else
		begin
			failCount++;
			$display("test %s: %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	task automatic compareField(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got == exp)
		else
		begin
			$display("FAILED %s got %h expected %h at cycle %0d", name, got, exp, cycleCount);
			errorCount++;
		end
	endtask

	// outputs still hold last cycle's values at this edge
	always @(posedge clk)
	begin
		logic dueNow;
		pendingOut head;
		cycleCount <= cycleCount + 1;
		if (rstN)
		begin
			dueNow = (expected.size() != 0) && (expected[0].due == cycleCount);
			if (expected.size() == 0)
			begin
				assert (!dutOut.valid)
				else
				begin
					$display("valid output at cycle %0d with no instruction pending",
						cycleCount);
					errorCount++;
				end
			end
			else
				compareField("dutOut.valid", {31'b0, dutOut.valid}, {31'b0, dueNow});
			if (dueNow)
			begin
				head = expected.pop_front();
				compareField("dutOut.result", dutOut.result, head.exp.result);
				compareField("dutOut.zero", {31'b0, dutOut.zero}, {31'b0, head.exp.zero});
				compareField("dutOut.overflow", {31'b0, dutOut.overflow},
					{31'b0, head.exp.overflow});
			end
		end
	end

	// watchdog
	initial
	begin
		while (cycleCount < timeoutCycles)
			@(posedge clk);
		$display("timeout after %0d cycles, pipeline did not drain", cycleCount);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		int startErrors;
		logic [31:0] a;
		logic [31:0] b;
		logic [15:0] imm;
		logic [31:0] seedValue;
		rstN = 1'b0;
		dutIn = '0;
		seedValue = $urandom(77);
		repeat (resetCycles)
			@(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		// idle slots then back-to-back instructions
		startErrors = errorCount;
		repeat (3)
			send(rType(exePkg::functAddu, 5'd0), $urandom, $urandom, 1'b0);
		repeat (4)
			send(rType(exePkg::functAddu, 5'd0), $urandom, $urandom, 1'b1);
		reportTest("reset and latency", startErrors);

		// r-type alu ops with negative operands on the first pass
		startErrors = errorCount;
		for (int k = 0; k < 3; k++)
			for (int f = 0; f < 9; f++)
			begin
				a = $urandom;
				b = $urandom;
				if (k == 0)
				begin
					a[31] = 1'b1;
					b[31] = 1'b1;
				end
				send(rType(aluFuncts[f], 5'd0), a, b, 1'b1);
			end
		reportTest("r-type alu", startErrors);

		// signed limits on flagged and unflagged forms
		startErrors = errorCount;
		for (int k = 0; k < 4; k++)
		begin
			send(rType(exePkg::functAdd, 5'd0), cornerA[k], cornerB[k], 1'b1);
			send(rType(exePkg::functAddu, 5'd0), cornerA[k], cornerB[k], 1'b1);
			send(rType(exePkg::functSub, 5'd0), cornerA[k], cornerB[k], 1'b1);
			send(rType(exePkg::functSubu, 5'd0), cornerA[k], cornerB[k], 1'b1);
		end
		send(iType(exePkg::opcodeAddi, 16'h0001), 32'h7fffffff, 32'h0, 1'b1);
		send(iType(exePkg::opcodeAddiu, 16'h0001), 32'h7fffffff, 32'h0, 1'b1);
		send(iType(exePkg::opcodeAddi, 16'hffff), 32'h80000000, 32'h0, 1'b1);
		send(iType(exePkg::opcodeAddiu, 16'hffff), 32'h80000000, 32'h0, 1'b1);
		reportTest("overflow corners", startErrors);

		// shifts with rt negative on odd passes
		startErrors = errorCount;
		for (int k = 0; k < 4; k++)
		begin
			b = $urandom;
			b[31] = k[0];
			send(rType(exePkg::functSll, 5'($urandom)), $urandom, b, 1'b1);
			send(rType(exePkg::functSrl, 5'($urandom)), $urandom, b, 1'b1);
			send(rType(exePkg::functSra, 5'($urandom)), $urandom, b, 1'b1);
			send(rType(exePkg::functSllv, 5'd0), $urandom, b, 1'b1);
			send(rType(exePkg::functSrlv, 5'd0), $urandom, b, 1'b1);
			send(iType(exePkg::opcodeLui, 16'($urandom)), $urandom, b, 1'b1);
		end
		reportTest("shifts", startErrors);

		// i-type with sign bit set in imm
		startErrors = errorCount;
		for (int k = 0; k < 3; k++)
		begin
			send(iType(exePkg::opcodeAddi, 16'($urandom) | 16'h8000), $urandom, 32'h0, 1'b1);
			send(iType(exePkg::opcodeAddiu, 16'($urandom) | 16'h8000), $urandom, 32'h0, 1'b1);
			send(iType(exePkg::opcodeSlti, 16'($urandom) | 16'h8000), $urandom, 32'h0, 1'b1);
			send(iType(exePkg::opcodeSltiu, 16'($urandom) | 16'h8000), $urandom, 32'h0, 1'b1);
			send(iType(exePkg::opcodeAndi, 16'($urandom) | 16'h8000), $urandom, 32'h0, 1'b1);
			send(iType(exePkg::opcodeOri, 16'($urandom) | 16'h8000), $urandom, 32'h0, 1'b1);
		end
		// beq with rs equal to the extended imm twice, then unequal twice
		for (int k = 0; k < 4; k++)
		begin
			imm = 16'($urandom);
			a = {{16{imm[15]}}, imm};
			if (k >= 2)
				a = a ^ 32'h00010000;
			send(iType(exePkg::opcodeBeq, imm), a, $urandom, 1'b1);
		end
		reportTest("i-type", startErrors);

		// jr and unknown encodings with bubbles in between
		startErrors = errorCount;
		repeat (3)
		begin
			send(rType(exePkg::functJr, 5'd0), $urandom, $urandom, 1'b1);
			send(rType(exePkg::functAdd, 5'd0), $urandom, $urandom, 1'b0);
		end
		send(iType(6'h3f, 16'($urandom)), $urandom, $urandom, 1'b1);
		send(iType(6'h23, 16'($urandom)), $urandom, $urandom, 1'b1);
		send(rType(6'h01, 5'($urandom)), $urandom, $urandom, 1'b1);
		send(rType(6'h3f, 5'($urandom)), $urandom, $urandom, 1'b1);
		send(rType(exePkg::functOr, 5'd0), $urandom, $urandom, 1'b0);
		reportTest("jr, unknown and bubbles", startErrors);

		$display("tests passed %0d, failed %0d, check errors %0d", passCount, failCount,
			errorCount);
		if (failCount == 0 && errorCount == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module exeStageTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/VexeStageTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1

//--- sim.f
+incdir+bench
source/exePkg.sv
source/aluControl.sv
source/operandSelect.sv
source/alu.sv
source/exeStage.sv
bench/exeStageTb.sv

//--- source/alu.sv
module alu
(
	input logic clk,
	input logic rstN,
	input exePkg::aluIn in,
	output exePkg::exeOut out
);

	logic [exePkg::dataWidth-1:0] sum;
	logic [exePkg::dataWidth-1:0] diff;
	logic addOverflow;
	logic subOverflow;
	logic [exePkg::dataWidth-1:0] resultNext;
	logic overflowNext;
	logic zeroNext;

	// shared adder and subtractor, rs minus b
	assign sum = in.a + in.b;
	assign diff = in.a - in.b;

	// signed overflow from the current sum
	// same-sign inputs, sign flipped in sum
	assign addOverflow = (in.a[exePkg::dataWidth-1] == in.b[exePkg::dataWidth-1]) &&
		(sum[exePkg::dataWidth-1] != in.a[exePkg::dataWidth-1]);
	// signs differ, result sign not that of a
	assign subOverflow = (in.a[exePkg::dataWidth-1] != in.b[exePkg::dataWidth-1]) &&
		(diff[exePkg::dataWidth-1] != in.a[exePkg::dataWidth-1]);

	always_comb
	begin
		resultNext = '0;
		overflowNext = 1'b0;
		case (in.op)
			exePkg::opAdd:
			begin
				resultNext = sum;
				overflowNext = addOverflow;
			end
			// unsigned forms never flag
			exePkg::opAddu:
				resultNext = sum;
			exePkg::opSub:
			begin
				resultNext = diff;
				overflowNext = subOverflow;
			end
			exePkg::opSubu:
				resultNext = diff;
			exePkg::opAnd:
				resultNext = in.a & in.b;
			exePkg::opOr:
				resultNext = in.a | in.b;
			exePkg::opNor:
				resultNext = ~(in.a | in.b);
			exePkg::opSlt:
				resultNext = {31'b0, $signed(in.a) < $signed(in.b)};
			exePkg::opSltu:
				resultNext = {31'b0, in.a < in.b};
			// shifts act on b, which is rt
			exePkg::opSll:
				resultNext = in.b << in.shamt;
			exePkg::opSrl:
				resultNext = in.b >> in.shamt;
			exePkg::opSra:
				resultNext = $signed(in.b) >>> in.shamt;
			// upper immediate, fixed shift of 16
			exePkg::opLui:
				resultNext = in.b << 16;
			// jr, rs straight through
			exePkg::opPass:
				resultNext = in.a;
			default:
			begin
				resultNext = '0;
				overflowNext = 1'b0;
			end
		endcase
	end

	// zero only for beq/sub/subu, and never with overflow
	assign zeroNext = in.reportsZero && (diff == '0) && !overflowNext;

	// stage 2 register
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			out <= '0;
		end
		else
		begin
			out.valid <= in.valid;
			out.result <= resultNext;
			out.zero <= zeroNext;
			out.overflow <= overflowNext;
		end
	end

endmodule

//--- source/aluControl.sv
module aluControl
(
	input exePkg::instrWord instr,
	output exePkg::aluCtrl ctrl
);

	always_comb
	begin
		// anything not matched below stays a nop
		ctrl = '0;
		ctrl.op = exePkg::opNop;
		if (instr.r.opcode == exePkg::opcodeRtype)
		begin
			// register format, decode by funct
			case (instr.r.funct)
				exePkg::functAdd:
					ctrl.op = exePkg::opAdd;
				exePkg::functAddu:
					ctrl.op = exePkg::opAddu;
				exePkg::functSub:
				begin
					ctrl.op = exePkg::opSub;
					ctrl.reportsZero = 1'b1;
				end
				exePkg::functSubu:
				begin
					ctrl.op = exePkg::opSubu;
					ctrl.reportsZero = 1'b1;
				end
				exePkg::functAnd:
					ctrl.op = exePkg::opAnd;
				exePkg::functOr:
					ctrl.op = exePkg::opOr;
				exePkg::functNor:
					ctrl.op = exePkg::opNor;
				exePkg::functSlt:
					ctrl.op = exePkg::opSlt;
				exePkg::functSltu:
					ctrl.op = exePkg::opSltu;
				// fixed shifts take shamt field
				exePkg::functSll:
					ctrl.op = exePkg::opSll;
				exePkg::functSrl:
					ctrl.op = exePkg::opSrl;
				exePkg::functSra:
					ctrl.op = exePkg::opSra;
				// variable shifts take rs low bits
				exePkg::functSllv:
				begin
					ctrl.op = exePkg::opSll;
					ctrl.shiftVariable = 1'b1;
				end
				exePkg::functSrlv:
				begin
					ctrl.op = exePkg::opSrl;
					ctrl.shiftVariable = 1'b1;
				end
				// jr just forwards rs
				exePkg::functJr:
					ctrl.op = exePkg::opPass;
				default:
					ctrl.op = exePkg::opNop;
			endcase
		end
		else
		begin
			// immediate format, decode by opcode
			ctrl.useImm = 1'b1;
			case (instr.i.opcode)
				exePkg::opcodeAddi:
					ctrl.op = exePkg::opAdd;
				exePkg::opcodeAddiu:
					ctrl.op = exePkg::opAddu;
				exePkg::opcodeSlti:
					ctrl.op = exePkg::opSlt;
				// sltiu still sign extends, compare is unsigned
				exePkg::opcodeSltiu:
					ctrl.op = exePkg::opSltu;
				exePkg::opcodeAndi:
				begin
					ctrl.op = exePkg::opAnd;
					ctrl.zeroExtend = 1'b1;
				end
				exePkg::opcodeOri:
				begin
					ctrl.op = exePkg::opOr;
					ctrl.zeroExtend = 1'b1;
				end
				exePkg::opcodeLui:
				begin
					ctrl.op = exePkg::opLui;
					ctrl.zeroExtend = 1'b1;
				end
				exePkg::opcodeBeq:
				begin
					ctrl.op = exePkg::opSub;
					ctrl.reportsZero = 1'b1;
				end
				default:
				begin
					ctrl.op = exePkg::opNop;
					ctrl.useImm = 1'b0;
				end
			endcase
		end
	end

endmodule

//--- source/exePkg.sv
package exePkg;

	// datapath widths
	localparam int dataWidth = 32;
	localparam int shamtWidth = 5;

	// alu operations, opNop must stay at zero
	typedef enum logic [3:0]
	{
		opNop,
		opAdd,
		opAddu,
		opSub,
		opSubu,
		opAnd,
		opOr,
		opNor,
		opSlt,
		opSltu,
		opSll,
		opSrl,
		opSra,
		opLui,
		opPass
	} aluOp;

	// primary opcodes
	localparam logic [5:0] opcodeRtype = 6'h00;
	localparam logic [5:0] opcodeBeq = 6'h04;
	localparam logic [5:0] opcodeAddi = 6'h08;
	localparam logic [5:0] opcodeAddiu = 6'h09;
	localparam logic [5:0] opcodeSlti = 6'h0a;
	localparam logic [5:0] opcodeSltiu = 6'h0b;
	localparam logic [5:0] opcodeAndi = 6'h0c;
	localparam logic [5:0] opcodeOri = 6'h0d;
	localparam logic [5:0] opcodeLui = 6'h0f;

	// r-type funct codes
	localparam logic [5:0] functSll = 6'h00;
	localparam logic [5:0] functSrl = 6'h02;
	localparam logic [5:0] functSra = 6'h03;
	localparam logic [5:0] functSllv = 6'h04;
	localparam logic [5:0] functSrlv = 6'h06;
	localparam logic [5:0] functJr = 6'h08;
	localparam logic [5:0] functAdd = 6'h20;
	localparam logic [5:0] functAddu = 6'h21;
	localparam logic [5:0] functSub = 6'h22;
	localparam logic [5:0] functSubu = 6'h23;
	localparam logic [5:0] functAnd = 6'h24;
	localparam logic [5:0] functOr = 6'h25;
	localparam logic [5:0] functNor = 6'h27;
	localparam logic [5:0] functSlt = 6'h2a;
	localparam logic [5:0] functSltu = 6'h2b;

	// register format view
	typedef struct packed
	{
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [shamtWidth-1:0] shamt;
		logic [5:0] funct;
	} rFields;

	// immediate format view
	typedef struct packed
	{
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} iFields;

	// same 32 bits, two decodings
	typedef union packed
	{
		rFields r;
		iFields i;
	} instrWord;

	// instruction plus register operands into the stage
	typedef struct packed
	{
		logic valid;
		instrWord instr;
		logic [dataWidth-1:0] rsValue;
		logic [dataWidth-1:0] rtValue;
	} exeIn;

	// decoder output
	typedef struct packed
	{
		aluOp op;
		logic useImm;
		logic zeroExtend;
		logic shiftVariable;
		logic reportsZero;
	} aluCtrl;

	// first pipeline register
	typedef struct packed
	{
		logic valid;
		aluOp op;
		logic reportsZero;
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		logic [shamtWidth-1:0] shamt;
	} aluIn;

	// second pipeline register, stage output
	typedef struct packed
	{
		logic valid;
		logic [dataWidth-1:0] result;
		logic zero;
		logic overflow;
	} exeOut;

endpackage

//--- source/exeStage.sv
module exeStage
(
	input logic clk,
	input logic rstN,
	input exePkg::exeIn in,
	output exePkg::exeOut out
);

	// decoded control, same cycle as the input
	exePkg::aluCtrl ctrl;
	// registered operands between the two stages
	exePkg::aluIn stageIn;

	// instruction word to operation
	aluControl u_aluControl
	(
		.instr(in.instr),
		.ctrl(ctrl)
	);

	// stage 1, operands
	operandSelect u_operandSelect
	(
		.clk(clk),
		.rstN(rstN),
		.in(in),
		.ctrl(ctrl),
		.out(stageIn)
	);

	// stage 2, result and flags
	alu u_alu
	(
		.clk(clk),
		.rstN(rstN),
		.in(stageIn),
		.out(out)
	);

endmodule

//--- source/operandSelect.sv
module operandSelect
(
	input logic clk,
	input logic rstN,
	input exePkg::exeIn in,
	input exePkg::aluCtrl ctrl,
	output exePkg::aluIn out
);

	logic [exePkg::dataWidth-1:0] immExt;
	logic [exePkg::dataWidth-1:0] bNext;
	logic [exePkg::shamtWidth-1:0] shamtNext;

	// 16-bit immediate to full width
	always_comb
	begin
		if (ctrl.zeroExtend)
			immExt = {16'b0, in.instr.i.imm};
		else
			immExt = {{16{in.instr.i.imm[15]}}, in.instr.i.imm};
	end

	// second operand, rt or immediate
	assign bNext = ctrl.useImm ? immExt : in.rtValue;

	// sllv/srlv shift by rs, others by the shamt field
	assign shamtNext = ctrl.shiftVariable ? in.rsValue[exePkg::shamtWidth-1:0] :
		in.instr.r.shamt;

	// stage 1 register
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			out <= '0;
		end
		else
		begin
			// bubbles advance too
			out.valid <= in.valid;
			out.op <= ctrl.op;
			out.reportsZero <= ctrl.reportsZero;
			out.a <= in.rsValue;
			out.b <= bNext;
			out.shamt <= shamtNext;
		end
	end

endmodule
